// File: src/ring_settings.svh
`ifndef RING_SETTINGS_SVH
`define RING_SETTINGS_SVH

`default_nettype none

// ring size, stations 1..RING_NODES are nodes, 0 is the nic
`define RING_NODES 4

// words held by each node mailbox
`define NODE_MEM_DEPTH 16

// payload word width
`define RING_DATA_W 32

// word address inside one node memory
`define RING_ADDR_W 4

// station id, wide enough for unused ids 5..7
`define RING_ID_W 3

`default_nettype wire

`endif

// File: src/ring_pkg.sv
`include "ring_settings.svh"
`default_nettype none

package ring_pkg;

	// ------------------------------------------------------------------
	// ring packet fields
	// ------------------------------------------------------------------

	// station id, 0 is the nic
	typedef logic [`RING_ID_W-1:0] node_id_t;

	// word address in a node memory
	typedef logic [`RING_ADDR_W-1:0] ring_addr_t;

	// payload word
	typedef logic [`RING_DATA_W-1:0] ring_data_t;

	// packet kind, msb set for responses
	typedef enum logic [1:0] {
		PKT_RD_REQ = 2'b00,
		PKT_WR_REQ = 2'b01,
		PKT_RD_RSP = 2'b10,
		PKT_WR_RSP = 2'b11
	} pkt_kind_e;

	// the nic station id
	localparam node_id_t NIC_ID = '0;

	// mailbox size
	localparam int NODE_MEM_DEPTH = `NODE_MEM_DEPTH;

endpackage

`default_nettype wire

// File: src/axil_pkg.sv
`include "ring_settings.svh"
`default_nettype none

package axil_pkg;

	// bresp / rresp codes in use
	typedef enum logic [1:0] {
		AXIL_OKAY   = 2'b00,
		AXIL_SLVERR = 2'b10
	} axil_resp_e;

	// byte offset into the nic register block
	typedef logic [4:0] reg_off_t;

	// register map
	localparam reg_off_t REG_CMD    = 5'h00;
	localparam reg_off_t REG_TXDATA = 5'h04;
	localparam reg_off_t REG_STATUS = 5'h08;
	localparam reg_off_t REG_RXDATA = 5'h0C;
	localparam reg_off_t REG_RXSRC  = 5'h10;

	// read data returned with slverr
	localparam logic [`RING_DATA_W-1:0] AXIL_ERR_DATA = '0;

endpackage

`default_nettype wire

// File: src/nic_regs.sv
`timescale 1ns/1ps
`default_nettype none

module nic_regs (
	input  logic                   clk80,
	input  logic                   rst_n_i,
	// host write address and data
	input  axil_pkg::reg_off_t     s_axil_awaddr_i,
	input  logic                   s_axil_awvalid_i,
	output logic                   s_axil_awready_o,
	input  ring_pkg::ring_data_t   s_axil_wdata_i,
	input  logic                   s_axil_wvalid_i,
	output logic                   s_axil_wready_o,
	output axil_pkg::axil_resp_e   s_axil_bresp_o,
	output logic                   s_axil_bvalid_o,
	input  logic                   s_axil_bready_i,
	// host read
	input  axil_pkg::reg_off_t     s_axil_araddr_i,
	input  logic                   s_axil_arvalid_i,
	output logic                   s_axil_arready_o,
	output ring_pkg::ring_data_t   s_axil_rdata_o,
	output axil_pkg::axil_resp_e   s_axil_rresp_o,
	output logic                   s_axil_rvalid_o,
	input  logic                   s_axil_rready_i,
	// command to the packet engine
	output logic                   cmd_start_o,
	output logic                   cmd_write_o,
	output ring_pkg::node_id_t     cmd_dst_o,
	output ring_pkg::ring_addr_t   cmd_addr_o,
	output ring_pkg::ring_data_t   cmd_data_o,
	// result from the packet engine
	input  logic                   eng_busy_i,
	input  logic                   eng_fin_i,
	input  ring_pkg::ring_data_t   eng_data_i,
	input  ring_pkg::node_id_t     eng_src_i,
	input  logic                   eng_no_node_i
);
	import ring_pkg::*;
	import axil_pkg::*;

	logic       wr_accept;
	logic       cmd_block;
	logic       cmd_accept;
	logic       tx_write;
	logic       rd_accept;
	ring_data_t tx_data_q;
	logic       done_q;
	logic       no_node_q;
	ring_data_t rx_data_q;
	node_id_t   rx_src_q;
	ring_data_t status_w;

	// ------------------------------------------------------------------
	// write channel
	// ------------------------------------------------------------------

	// busy covers the start pulse and the finish cycle too
	assign cmd_block = eng_busy_i | eng_fin_i | cmd_start_o;

	// aw and w taken together, one response outstanding at most
	assign wr_accept        = s_axil_awvalid_i & s_axil_wvalid_i & ~s_axil_bvalid_o;
	assign s_axil_awready_o = wr_accept;
	assign s_axil_wready_o  = wr_accept;

	assign cmd_accept = wr_accept && (s_axil_awaddr_i == REG_CMD) && !cmd_block;
	assign tx_write   = wr_accept && (s_axil_awaddr_i == REG_TXDATA);

	always_ff @(posedge clk80) begin
		if (!rst_n_i) begin
			s_axil_bvalid_o <= 1'b0;
			s_axil_bresp_o  <= AXIL_OKAY;
			cmd_start_o     <= 1'b0;
		end else begin
			// start is a single cycle pulse
			cmd_start_o <= cmd_accept;
			if (s_axil_bvalid_o && s_axil_bready_i)
				s_axil_bvalid_o <= 1'b0;
			if (wr_accept) begin
				s_axil_bvalid_o <= 1'b1;
				// refused cmd, read-only and unmapped all end here
				if (cmd_accept || tx_write)
					s_axil_bresp_o <= AXIL_OKAY;
				else
					s_axil_bresp_o <= AXIL_SLVERR;
			end
		end
	end

	// command fields and tx word
	always_ff @(posedge clk80) begin
		if (tx_write)
			tx_data_q <= s_axil_wdata_i;
		if (cmd_accept) begin
			cmd_write_o <= s_axil_wdata_i[0];
			cmd_dst_o   <= node_id_t'(s_axil_wdata_i[6:4]);
			cmd_addr_o  <= ring_addr_t'(s_axil_wdata_i[11:8]);
		end
	end

	// engine samples this with the start pulse
	assign cmd_data_o = tx_data_q;

	// ------------------------------------------------------------------
	// result capture
	// ------------------------------------------------------------------

	always_ff @(posedge clk80) begin
		if (!rst_n_i) begin
			done_q    <= 1'b0;
			no_node_q <= 1'b0;
			rx_data_q <= '0;
			rx_src_q  <= '0;
		end else if (eng_fin_i) begin
			done_q    <= 1'b1;
			no_node_q <= eng_no_node_i;
			rx_data_q <= eng_data_i;
			rx_src_q  <= eng_src_i;
		end else if (cmd_accept) begin
			// new command clears the sticky flags
			done_q    <= 1'b0;
			no_node_q <= 1'b0;
		end
	end

	// bit 0 busy, bit 1 done, bit 2 no_node
	assign status_w = ring_data_t'({no_node_q, done_q, cmd_block});

	// ------------------------------------------------------------------
	// read channel
	// ------------------------------------------------------------------

	assign rd_accept        = s_axil_arvalid_i & ~s_axil_rvalid_o;
	assign s_axil_arready_o = ~s_axil_rvalid_o;

	always_ff @(posedge clk80) begin
		if (!rst_n_i) begin
			s_axil_rvalid_o <= 1'b0;
			s_axil_rresp_o  <= AXIL_OKAY;
			s_axil_rdata_o  <= '0;
		end else begin
			if (s_axil_rvalid_o && s_axil_rready_i)
				s_axil_rvalid_o <= 1'b0;
			if (rd_accept) begin
				s_axil_rvalid_o <= 1'b1;
				s_axil_rresp_o  <= AXIL_OKAY;
				case (s_axil_araddr_i)
					REG_TXDATA: s_axil_rdata_o <= tx_data_q;
					REG_STATUS: s_axil_rdata_o <= status_w;
					REG_RXDATA: s_axil_rdata_o <= rx_data_q;
					REG_RXSRC:  s_axil_rdata_o <= ring_data_t'(rx_src_q);
					default: begin
						// cmd is write only, treated as unmapped
						s_axil_rresp_o <= AXIL_SLVERR;
						s_axil_rdata_o <= AXIL_ERR_DATA;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: src/nic_engine.sv
`timescale 1ns/1ps
`default_nettype none

module nic_engine (
	input  logic                  clk80,
	input  logic                  rst_n_i,
	// command from the register block
	input  logic                  cmd_start_i,
	input  logic                  cmd_write_i,
	input  ring_pkg::node_id_t    cmd_dst_i,
	input  ring_pkg::ring_addr_t  cmd_addr_i,
	input  ring_pkg::ring_data_t  cmd_data_i,
	// status back
	output logic                  busy_o,
	output logic                  fin_o,
	output ring_pkg::ring_data_t  fin_data_o,
	output ring_pkg::node_id_t    fin_src_o,
	output logic                  fin_no_node_o,
	// ring in, from the last node
	input  logic                  pkt_vld_i,
	input  ring_pkg::pkt_kind_e   pkt_kind_i,
	input  ring_pkg::node_id_t    pkt_dst_i,
	input  ring_pkg::node_id_t    pkt_src_i,
	input  ring_pkg::ring_addr_t  pkt_addr_i,
	input  ring_pkg::ring_data_t  pkt_data_i,
	// ring out, to the first node
	output logic                  pkt_vld_o,
	output ring_pkg::pkt_kind_e   pkt_kind_o,
	output ring_pkg::node_id_t    pkt_dst_o,
	output ring_pkg::node_id_t    pkt_src_o,
	output ring_pkg::ring_addr_t  pkt_addr_o,
	output ring_pkg::ring_data_t  pkt_data_o
);
	import ring_pkg::*;

	typedef enum logic [1:0] {IDLE, WAIT_SLOT, WAIT_RSP} eng_state_e;

	eng_state_e state_q;
	logic       req_write_q;
	node_id_t   req_dst_q;
	ring_addr_t req_addr_q;
	ring_data_t req_data_q;
	logic       rsp_hit;
	logic       req_back;
	logic       inject;
	logic       remove;

	// response for the nic
	assign rsp_hit = pkt_vld_i && (pkt_dst_i == NIC_ID)
		&& (pkt_kind_i == PKT_RD_RSP || pkt_kind_i == PKT_WR_RSP);
	// own request went round unserved, no such node
	assign req_back = pkt_vld_i && (pkt_src_i == NIC_ID)
		&& (pkt_kind_i == PKT_RD_REQ || pkt_kind_i == PKT_WR_REQ);

	assign inject = (state_q == WAIT_SLOT) && !pkt_vld_i;
	assign remove = (state_q == WAIT_RSP) && (rsp_hit || req_back);
	assign busy_o = (state_q != IDLE);

	// ------------------------------------------------------------------
	// control
	// ------------------------------------------------------------------

	always_ff @(posedge clk80) begin
		if (!rst_n_i) begin
			state_q   <= IDLE;
			pkt_vld_o <= 1'b0;
			fin_o     <= 1'b0;
		end else begin
			fin_o <= remove;
			// slot kept, filled or emptied
			if (inject)
				pkt_vld_o <= 1'b1;
			else if (remove)
				pkt_vld_o <= 1'b0;
			else
				pkt_vld_o <= pkt_vld_i;
			case (state_q)
				IDLE:      if (cmd_start_i) state_q <= WAIT_SLOT;
				WAIT_SLOT: if (inject) state_q <= WAIT_RSP;
				WAIT_RSP:  if (remove) state_q <= IDLE;
				default:   state_q <= IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// packet and result fields
	// ------------------------------------------------------------------

	always_ff @(posedge clk80) begin
		if (state_q == IDLE && cmd_start_i) begin
			req_write_q <= cmd_write_i;
			req_dst_q   <= cmd_dst_i;
			req_addr_q  <= cmd_addr_i;
			req_data_q  <= cmd_data_i;
		end
		if (inject) begin
			pkt_kind_o <= req_write_q ? PKT_WR_REQ : PKT_RD_REQ;
			pkt_dst_o  <= req_dst_q;
			pkt_src_o  <= NIC_ID;
			pkt_addr_o <= req_addr_q;
			pkt_data_o <= req_data_q;
		end else begin
			// foreign traffic passes one hop
			pkt_kind_o <= pkt_kind_i;
			pkt_dst_o  <= pkt_dst_i;
			pkt_src_o  <= pkt_src_i;
			pkt_addr_o <= pkt_addr_i;
			pkt_data_o <= pkt_data_i;
		end
		if (remove) begin
			// no data when nobody answered
			fin_data_o    <= req_back ? '0 : pkt_data_i;
			fin_src_o     <= pkt_src_i;
			fin_no_node_o <= req_back;
		end
	end

endmodule

`default_nettype wire

// File: src/ring_node.sv
`timescale 1ns/1ps
`default_nettype none

module ring_node #(
	parameter ring_pkg::node_id_t NODE_ID = ring_pkg::node_id_t'(1)
) (
	input  logic                  clk80,
	input  logic                  rst_n_i,
	// upstream hop
	input  logic                  pkt_vld_i,
	input  ring_pkg::pkt_kind_e   pkt_kind_i,
	input  ring_pkg::node_id_t    pkt_dst_i,
	input  ring_pkg::node_id_t    pkt_src_i,
	input  ring_pkg::ring_addr_t  pkt_addr_i,
	input  ring_pkg::ring_data_t  pkt_data_i,
	// downstream hop
	output logic                  pkt_vld_o,
	output ring_pkg::pkt_kind_e   pkt_kind_o,
	output ring_pkg::node_id_t    pkt_dst_o,
	output ring_pkg::node_id_t    pkt_src_o,
	output ring_pkg::ring_addr_t  pkt_addr_o,
	output ring_pkg::ring_data_t  pkt_data_o
);
	import ring_pkg::*;

	// mailbox memory
	ring_data_t mem_q [NODE_MEM_DEPTH];

	logic serve;
	logic serve_wr;

	// request for this station
	assign serve = pkt_vld_i && (pkt_dst_i == NODE_ID)
		&& (pkt_kind_i == PKT_RD_REQ || pkt_kind_i == PKT_WR_REQ);
	assign serve_wr = serve && (pkt_kind_i == PKT_WR_REQ);

	// ------------------------------------------------------------------
	// mailbox
	// ------------------------------------------------------------------

	always_ff @(posedge clk80) begin
		if (!rst_n_i) begin
			// mailbox comes up all zero
			for (int i = 0; i < NODE_MEM_DEPTH; i++)
				mem_q[i] <= '0;
		end else if (serve_wr) begin
			mem_q[pkt_addr_i] <= pkt_data_i;
		end
	end

	// ------------------------------------------------------------------
	// slot register
	// ------------------------------------------------------------------

	// slot occupancy never changes here, a request turns into its response
	always_ff @(posedge clk80) begin
		if (!rst_n_i)
			pkt_vld_o <= 1'b0;
		else
			pkt_vld_o <= pkt_vld_i;
	end

	always_ff @(posedge clk80) begin
		if (serve) begin
			// answer goes back to the requester
			pkt_kind_o <= serve_wr ? PKT_WR_RSP : PKT_RD_RSP;
			pkt_dst_o  <= pkt_src_i;
			pkt_src_o  <= NODE_ID;
			pkt_addr_o <= pkt_addr_i;
			// write echoes its data, read returns the stored word
			pkt_data_o <= serve_wr ? pkt_data_i : mem_q[pkt_addr_i];
		end else begin
			// pass through
			pkt_kind_o <= pkt_kind_i;
			pkt_dst_o  <= pkt_dst_i;
			pkt_src_o  <= pkt_src_i;
			pkt_addr_o <= pkt_addr_i;
			pkt_data_o <= pkt_data_i;
		end
	end

endmodule

`default_nettype wire

// File: src/ring_soc.sv
`timescale 1ns/1ps
`include "ring_settings.svh"
`default_nettype none

module ring_soc (
	input  logic                  clk80,
	input  logic                  rst_n_i,
	// host port
	input  axil_pkg::reg_off_t    s_axil_awaddr_i,
	input  logic                  s_axil_awvalid_i,
	output logic                  s_axil_awready_o,
	input  ring_pkg::ring_data_t  s_axil_wdata_i,
	input  logic                  s_axil_wvalid_i,
	output logic                  s_axil_wready_o,
	output axil_pkg::axil_resp_e  s_axil_bresp_o,
	output logic                  s_axil_bvalid_o,
	input  logic                  s_axil_bready_i,
	input  axil_pkg::reg_off_t    s_axil_araddr_i,
	input  logic                  s_axil_arvalid_i,
	output logic                  s_axil_arready_o,
	output ring_pkg::ring_data_t  s_axil_rdata_o,
	output axil_pkg::axil_resp_e  s_axil_rresp_o,
	output logic                  s_axil_rvalid_o,
	input  logic                  s_axil_rready_i
);
	import ring_pkg::*;

	// register block to engine
	logic       cmd_start;
	logic       cmd_write;
	node_id_t   cmd_dst;
	ring_addr_t cmd_addr;
	ring_data_t cmd_data;
	logic       eng_busy;
	logic       eng_fin;
	ring_data_t eng_data;
	node_id_t   eng_src;
	logic       eng_no_node;

	// ring hops, 0 leaves the nic, RING_NODES returns to it
	logic       ring_vld  [`RING_NODES+1];
	pkt_kind_e  ring_kind [`RING_NODES+1];
	node_id_t   ring_dst  [`RING_NODES+1];
	node_id_t   ring_src  [`RING_NODES+1];
	ring_addr_t ring_addr [`RING_NODES+1];
	ring_data_t ring_data [`RING_NODES+1];

	nic_regs u_regs (
		.clk80(clk80), .rst_n_i(rst_n_i),
		.s_axil_awaddr_i(s_axil_awaddr_i), .s_axil_awvalid_i(s_axil_awvalid_i),
		.s_axil_awready_o(s_axil_awready_o), .s_axil_wdata_i(s_axil_wdata_i),
		.s_axil_wvalid_i(s_axil_wvalid_i), .s_axil_wready_o(s_axil_wready_o),
		.s_axil_bresp_o(s_axil_bresp_o), .s_axil_bvalid_o(s_axil_bvalid_o),
		.s_axil_bready_i(s_axil_bready_i), .s_axil_araddr_i(s_axil_araddr_i),
		.s_axil_arvalid_i(s_axil_arvalid_i), .s_axil_arready_o(s_axil_arready_o),
		.s_axil_rdata_o(s_axil_rdata_o), .s_axil_rresp_o(s_axil_rresp_o),
		.s_axil_rvalid_o(s_axil_rvalid_o), .s_axil_rready_i(s_axil_rready_i),
		.cmd_start_o(cmd_start), .cmd_write_o(cmd_write), .cmd_dst_o(cmd_dst),
		.cmd_addr_o(cmd_addr), .cmd_data_o(cmd_data),
		.eng_busy_i(eng_busy), .eng_fin_i(eng_fin), .eng_data_i(eng_data),
		.eng_src_i(eng_src), .eng_no_node_i(eng_no_node)
	);

	// station 0
	nic_engine u_engine (
		.clk80(clk80), .rst_n_i(rst_n_i),
		.cmd_start_i(cmd_start), .cmd_write_i(cmd_write), .cmd_dst_i(cmd_dst),
		.cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data),
		.busy_o(eng_busy), .fin_o(eng_fin), .fin_data_o(eng_data),
		.fin_src_o(eng_src), .fin_no_node_o(eng_no_node),
		.pkt_vld_i(ring_vld[`RING_NODES]), .pkt_kind_i(ring_kind[`RING_NODES]),
		.pkt_dst_i(ring_dst[`RING_NODES]), .pkt_src_i(ring_src[`RING_NODES]),
		.pkt_addr_i(ring_addr[`RING_NODES]), .pkt_data_i(ring_data[`RING_NODES]),
		.pkt_vld_o(ring_vld[0]), .pkt_kind_o(ring_kind[0]),
		.pkt_dst_o(ring_dst[0]), .pkt_src_o(ring_src[0]),
		.pkt_addr_o(ring_addr[0]), .pkt_data_o(ring_data[0])
	);

	// nodes 1..RING_NODES, hop i feeds node i+1
	for (genvar i = 0; i < `RING_NODES; i++) begin : g_node
		ring_node #(
			.NODE_ID(node_id_t'(i + 1))
		) u_node (
			.clk80(clk80), .rst_n_i(rst_n_i),
			.pkt_vld_i(ring_vld[i]), .pkt_kind_i(ring_kind[i]),
			.pkt_dst_i(ring_dst[i]), .pkt_src_i(ring_src[i]),
			.pkt_addr_i(ring_addr[i]), .pkt_data_i(ring_data[i]),
			.pkt_vld_o(ring_vld[i+1]), .pkt_kind_o(ring_kind[i+1]),
			.pkt_dst_o(ring_dst[i+1]), .pkt_src_o(ring_src[i+1]),
			.pkt_addr_o(ring_addr[i+1]), .pkt_data_o(ring_data[i+1])
		);
	end

endmodule

`default_nettype wire

// File: verif/ring_soc_tb.sv
`timescale 1ns/1ps
`include "ring_settings.svh"
`default_nettype none

module ring_soc_tb;
	import ring_pkg::*;
	import axil_pkg::*;

	localparam int CLK_PERIOD     = 10;
	// about 100 transactions, 200 cycles each
	localparam int TXN_BUDGET     = 100;
	localparam int CYCLES_PER_TXN = 200;
	localparam int POLL_LIMIT     = 200;
	localparam int RAND_TXNS      = 64;
	localparam ring_data_t STATUS_DONE    = 32'h2;
	localparam ring_data_t STATUS_NO_NODE = 32'h6;
	localparam reg_off_t   REG_UNMAPPED   = 5'h14;

	logic       clk80;
	logic       rst_n_i;
	reg_off_t   s_axil_awaddr_i;
	logic       s_axil_awvalid_i;
	logic       s_axil_awready_o;
	ring_data_t s_axil_wdata_i;
	logic       s_axil_wvalid_i;
	logic       s_axil_wready_o;
	axil_resp_e s_axil_bresp_o;
	logic       s_axil_bvalid_o;
	logic       s_axil_bready_i;
	reg_off_t   s_axil_araddr_i;
	logic       s_axil_arvalid_i;
	logic       s_axil_arready_o;
	ring_data_t s_axil_rdata_o;
	axil_resp_e s_axil_rresp_o;
	logic       s_axil_rvalid_o;
	logic       s_axil_rready_i;

	// reference copy of every node mailbox
	ring_data_t  ref_mem [1:`RING_NODES][0:`NODE_MEM_DEPTH-1];
	logic [31:0] rng_state;
	int          mismatch_count;
	int          failure_count;

	ring_soc u_dut (
		.clk80(clk80), .rst_n_i(rst_n_i),
		.s_axil_awaddr_i(s_axil_awaddr_i), .s_axil_awvalid_i(s_axil_awvalid_i),
		.s_axil_awready_o(s_axil_awready_o), .s_axil_wdata_i(s_axil_wdata_i),
		.s_axil_wvalid_i(s_axil_wvalid_i), .s_axil_wready_o(s_axil_wready_o),
		.s_axil_bresp_o(s_axil_bresp_o), .s_axil_bvalid_o(s_axil_bvalid_o),
		.s_axil_bready_i(s_axil_bready_i), .s_axil_araddr_i(s_axil_araddr_i),
		.s_axil_arvalid_i(s_axil_arvalid_i), .s_axil_arready_o(s_axil_arready_o),
		.s_axil_rdata_o(s_axil_rdata_o), .s_axil_rresp_o(s_axil_rresp_o),
		.s_axil_rvalid_o(s_axil_rvalid_o), .s_axil_rready_i(s_axil_rready_i)
	);

	always #(CLK_PERIOD / 2) clk80 = ~clk80;

	// watchdog
	initial begin
		#(TXN_BUDGET * CYCLES_PER_TXN * CLK_PERIOD);
		$display("watchdog expired, the run did not finish in time");
		$display("TESTS FAILED");
		$finish;
	end

	// ------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// cmd layout: bit 0 write, 6:4 dst, 11:8 word address
	function automatic ring_data_t cmd_word(input logic wr, input node_id_t dst,
			input ring_addr_t addr);
		ring_data_t w;
		w = '0;
		w[0] = wr;
		w[6:4] = dst;
		w[11:8] = addr;
		return w;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("Fail %s: expected %h, actual %h", name, exp, act);
		mismatch_count++;
	endtask

	task automatic report_failure(input string what);
		$display("Error: %s", what);
		failure_count++;
	endtask

	// ------------------------------------------------------------------
	// axi4-lite host tasks
	// ------------------------------------------------------------------

	task automatic axil_write(input reg_off_t addr, input ring_data_t data,
			output axil_resp_e resp);
		@(posedge clk80);
		#1;
		s_axil_awaddr_i  = addr;
		s_axil_wdata_i   = data;
		s_axil_awvalid_i = 1'b1;
		s_axil_wvalid_i  = 1'b1;
		s_axil_bready_i  = 1'b1;
		// ready is settled by mid cycle
		@(negedge clk80);
		while (!s_axil_awready_o) begin
			if (s_axil_wready_o)
				report_failure("wready raised without awready");
			@(negedge clk80);
		end
		// aw and w handshake in the same cycle
		if (!s_axil_wready_o)
			report_failure("wready low in the aw handshake cycle");
		@(posedge clk80);
		#1;
		s_axil_awvalid_i = 1'b0;
		s_axil_wvalid_i  = 1'b0;
		@(negedge clk80);
		while (!s_axil_bvalid_o)
			@(negedge clk80);
		resp = s_axil_bresp_o;
		@(posedge clk80);
		#1;
		s_axil_bready_i = 1'b0;
	endtask

	task automatic axil_read(input reg_off_t addr, output ring_data_t data,
			output axil_resp_e resp);
		@(posedge clk80);
		#1;
		s_axil_araddr_i  = addr;
		s_axil_arvalid_i = 1'b1;
		s_axil_rready_i  = 1'b1;
		@(negedge clk80);
		while (!s_axil_arready_o)
			@(negedge clk80);
		@(posedge clk80);
		#1;
		s_axil_arvalid_i = 1'b0;
		@(negedge clk80);
		while (!s_axil_rvalid_o)
			@(negedge clk80);
		data = s_axil_rdata_o;
		resp = s_axil_rresp_o;
		@(posedge clk80);
		#1;
		s_axil_rready_i = 1'b0;
	endtask

	// ------------------------------------------------------------------
	// nic transactions
	// ------------------------------------------------------------------

	task automatic start_txn(input logic wr, input node_id_t dst, input ring_addr_t addr,
			input ring_data_t data);
		axil_resp_e resp;
		axil_write(REG_TXDATA, data, resp);
		if (resp !== AXIL_OKAY)
			report_mismatch("txdata write resp", AXIL_OKAY, resp);
		axil_write(REG_CMD, cmd_word(wr, dst, addr), resp);
		if (resp !== AXIL_OKAY)
			report_mismatch("cmd write resp", AXIL_OKAY, resp);
	endtask

	// poll until busy drops, then fetch the result registers
	task automatic wait_txn(output ring_data_t status, output ring_data_t rx_data,
			output ring_data_t rx_src);
		axil_resp_e resp;
		int polls;
		polls  = 0;
		status = '1;
		while (status[0] && polls < POLL_LIMIT) begin
			axil_read(REG_STATUS, status, resp);
			polls++;
		end
		if (status[0])
			report_failure("transaction still busy after the polling limit");
		axil_read(REG_RXDATA, rx_data, resp);
		axil_read(REG_RXSRC, rx_src, resp);
	endtask

	task automatic do_txn(input logic wr, input node_id_t dst, input ring_addr_t addr,
			input ring_data_t data, output ring_data_t status, output ring_data_t rx_data,
			output ring_data_t rx_src);
		start_txn(wr, dst, addr, data);
		wait_txn(status, rx_data, rx_src);
	endtask

	task automatic check_result(input string name, input ring_data_t status,
			input ring_data_t exp_status, input ring_data_t rx_data,
			input ring_data_t exp_data, input ring_data_t rx_src, input ring_data_t exp_src);
		if (status !== exp_status)
			report_mismatch({name, " status"}, exp_status, status);
		if (rx_data !== exp_data)
			report_mismatch({name, " rxdata"}, exp_data, rx_data);
		if (rx_src !== exp_src)
			report_mismatch({name, " rxsrc"}, exp_src, rx_src);
	endtask

	// write through a node and mirror it, or read and compare with the mirror
	task automatic node_access(input string name, input logic wr, input int n,
			input ring_addr_t addr, input ring_data_t data);
		ring_data_t status;
		ring_data_t rx_data;
		ring_data_t rx_src;
		do_txn(wr, node_id_t'(n), addr, data, status, rx_data, rx_src);
		if (wr)
			ref_mem[n][addr] = data;
		check_result(name, status, STATUS_DONE, rx_data, ref_mem[n][addr], rx_src, n);
	endtask

	// ------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------

	task automatic test_reset();
		ring_data_t val;
		axil_resp_e resp;
		axil_read(REG_STATUS, val, resp);
		if (resp !== AXIL_OKAY)
			report_mismatch("reset status resp", AXIL_OKAY, resp);
		if (val !== '0)
			report_mismatch("reset status", 0, val);
		axil_read(REG_RXDATA, val, resp);
		if (val !== '0)
			report_mismatch("reset rxdata", 0, val);
		axil_read(REG_RXSRC, val, resp);
		if (val !== '0)
			report_mismatch("reset rxsrc", 0, val);
	endtask

	task automatic test_each_node();
		ring_addr_t addr;
		for (int n = 1; n <= `RING_NODES; n++) begin
			addr = ring_addr_t'(n + 2);
			node_access($sformatf("node %0d write", n), 1'b1, n, addr, rand_word());
			node_access($sformatf("node %0d read", n), 1'b0, n, addr, '0);
		end
	endtask

	task automatic test_independent();
		// same word on every node, distinct values
		for (int n = 1; n <= `RING_NODES; n++)
			node_access("shared addr write", 1'b1, n, 4'd9, 32'ha5a5_0000 | n);
		for (int n = 1; n <= `RING_NODES; n++)
			node_access($sformatf("shared addr node %0d", n), 1'b0, n, 4'd9, '0);
		// word 15 is never written before this point
		for (int n = 1; n <= `RING_NODES; n++)
			node_access($sformatf("unwritten node %0d", n), 1'b0, n, 4'd15, '0);
	endtask

	task automatic test_no_node();
		ring_data_t status;
		ring_data_t rx_data;
		ring_data_t rx_src;
		for (int id = `RING_NODES + 1; id < (1 << `RING_ID_W); id++) begin
			do_txn(1'b1, node_id_t'(id), 4'd9, rand_word(), status, rx_data, rx_src);
			check_result($sformatf("no node %0d write", id), status, STATUS_NO_NODE,
				rx_data, 0, rx_src, 0);
		end
		do_txn(1'b0, node_id_t'(6), 4'd9, '0, status, rx_data, rx_src);
		check_result("no node read", status, STATUS_NO_NODE, rx_data, 0, rx_src, 0);
		// memories must still match the mirror
		for (int n = 1; n <= `RING_NODES; n++)
			node_access($sformatf("after no node %0d", n), 1'b0, n, 4'd9, '0);
	endtask

	task automatic test_errors();
		ring_data_t status;
		ring_data_t rx_data;
		ring_data_t rx_src;
		ring_data_t val;
		ring_data_t data;
		axil_resp_e resp;
		data = rand_word();
		start_txn(1'b1, node_id_t'(3), 4'd12, data);
		// second command straight away, engine still busy
		axil_write(REG_CMD, cmd_word(1'b1, node_id_t'(1), 4'd12), resp);
		if (resp !== AXIL_SLVERR)
			report_mismatch("busy cmd resp", AXIL_SLVERR, resp);
		wait_txn(status, rx_data, rx_src);
		ref_mem[3][12] = data;
		check_result("first of two cmds", status, STATUS_DONE, rx_data, data, rx_src, 3);
		// refused write must not reach node 1
		node_access("refused cmd target", 1'b0, 1, 4'd12, 32'h0bad_0001);
		axil_write(REG_UNMAPPED, 32'hdead_beef, resp);
		if (resp !== AXIL_SLVERR)
			report_mismatch("unmapped write resp", AXIL_SLVERR, resp);
		axil_write(REG_STATUS, 32'hffff_ffff, resp);
		if (resp !== AXIL_SLVERR)
			report_mismatch("status write resp", AXIL_SLVERR, resp);
		axil_write(REG_RXSRC, 32'h7, resp);
		if (resp !== AXIL_SLVERR)
			report_mismatch("rxsrc write resp", AXIL_SLVERR, resp);
		axil_read(REG_UNMAPPED, val, resp);
		if (resp !== AXIL_SLVERR)
			report_mismatch("unmapped read resp", AXIL_SLVERR, resp);
		if (val !== '0)
			report_mismatch("unmapped read data", 0, val);
		// nothing changed by the refused writes
		axil_read(REG_STATUS, val, resp);
		if (val !== STATUS_DONE)
			report_mismatch("status after errors", STATUS_DONE, val);
		axil_read(REG_RXSRC, val, resp);
		if (val !== 1)
			report_mismatch("rxsrc after errors", 1, val);
		axil_read(REG_TXDATA, val, resp);
		if (val !== 32'h0bad_0001)
			report_mismatch("txdata after errors", 32'h0bad_0001, val);
	endtask

	task automatic test_random();
		logic [31:0] r;
		int n;
		for (int i = 0; i < RAND_TXNS; i++) begin
			r = rand_word();
			n = 1 + r[1:0];
			node_access($sformatf("random %0d node %0d", i, n), r[8], n,
				ring_addr_t'(r[7:4]), rand_word());
		end
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------

	initial begin
		clk80            = 1'b0;
		rst_n_i          = 1'b0;
		s_axil_awaddr_i  = '0;
		s_axil_awvalid_i = 1'b0;
		s_axil_wdata_i   = '0;
		s_axil_wvalid_i  = 1'b0;
		s_axil_bready_i  = 1'b0;
		s_axil_araddr_i  = '0;
		s_axil_arvalid_i = 1'b0;
		s_axil_rready_i  = 1'b0;
		rng_state        = 32'hf649cc93;
		mismatch_count   = 0;
		failure_count    = 0;
		for (int n = 1; n <= `RING_NODES; n++)
			for (int a = 0; a < `NODE_MEM_DEPTH; a++)
				ref_mem[n][a] = '0;
		repeat (4) @(posedge clk80);
		#1;
		rst_n_i = 1'b1;
		test_reset();
		test_each_node();
		test_independent();
		test_no_node();
		test_errors();
		test_random();
		$display("value mismatches: %0d, other failures: %0d", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+src
src/ring_pkg.sv
src/axil_pkg.sv
src/nic_regs.sv
src/nic_engine.sv
src/ring_node.sv
src/ring_soc.sv
verif/ring_soc_tb.sv
